// ==== bench/ex_cases.txt ====
// Columns: pc instr rs1_val rs2_val in_bubble exp_bubble exp_r
// Last line is the end marker, all ones
00000100 003100b3 7fffffff 00000001 0 0 80000000
00000104 403100b3 00000000 00000001 0 0 ffffffff
00000108 fff10093 80000000 00000000 0 0 7fffffff
0000010c 003140b3 a5a5a5a5 ffff0000 0 0 5a5aa5a5
00000110 003160b3 12340000 00005678 0 0 12345678
00000114 003170b3 f0f0f0f0 3c3c3c3c 0 0 30303030
00000118 003120b3 80000000 7fffffff 0 0 00000001
0000011c 003130b3 80000000 7fffffff 0 0 00000000
00000120 fff12093 80000000 00000000 0 0 00000001
00000124 fff13093 80000000 00000000 0 0 00000001
00000128 003110b3 00000001 0000001f 0 0 80000000
0000012c 00011093 deadbeef 00000000 0 0 deadbeef
00000130 01f11093 00000003 00000000 0 0 80000000
00000134 003150b3 80000000 0000001f 0 0 00000001
00000138 403150b3 80000000 0000001f 0 0 ffffffff
0000013c 403150b3 80000000 00000000 0 0 80000000
00000140 40115093 fffffff0 00000000 0 0 fffffff8
00000144 00115093 fffffff0 00000000 0 0 7ffffff8
00000148 123450b7 55555555 00000000 0 0 12345000
80000ffc 00001097 00000000 00000000 0 0 80001ffc
00000200 008000ef 00000000 00000000 0 0 00000204
fffffffc 000100e7 00001234 00000000 0 0 00000000
00000300 340110f3 cafef00d 00000000 0 0 00000000
00000304 340020f3 00000000 00000000 0 0 cafef00d
00000308 340130f3 0000f00d 00000000 0 0 cafef00d
0000030c 340fe0f3 00000000 00000000 0 0 cafe0000
00000310 3402f0f3 00000000 00000000 0 0 cafe001f
00000314 340020f3 00000000 00000000 0 0 cafe001a
00000318 305110f3 00001237 00000000 0 0 00000000
0000031c 305bd0f3 00000000 00000000 0 0 00001234
00000320 305020f3 00000000 00000000 0 0 00000014
00000324 7c0110f3 ffffffff 00000000 0 0 00000000
00000328 7c0020f3 00000000 00000000 0 0 00000000
0000032c 340110f3 11111111 00000000 1 1 00000000
00000330 340110d3 22222222 00000000 0 1 00000000
00000334 00000073 00000000 00000000 0 1 00000000
00000338 023100b3 00000003 00000004 0 1 00000000
0000033c 340020f3 00000000 00000000 0 0 cafe001a
00000340 341110f3 80000040 00000000 0 0 00000000
00000344 341020f3 00000000 00000000 0 0 80000040
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff

// ==== filelist.f ====
hw/rv_ex_pkg.sv
hw/rv_operand_sel.sv
hw/rv_alu.sv
hw/rv_csr_file.sv
hw/rv_ex_top.sv
bench/rv_ex_assertions.sv
bench/rv_ex_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute-stage testbench with Verilator.
# Exits non-zero when the build fails, the run fails or the log reports failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f filelist.f --top-module rv_ex_tb \
  -Mdir "$OBJ" -o rv_ex_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$OBJ/rv_ex_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

// ==== bench/rv_ex_tb.sv ====
////////////////////
// Testbench of the execute stage, run from the project root
// Cases come from bench/ex_cases.txt, 7 hex words per line, end marker line
// Random stall cycles are inserted between cases from a fixed LFSR seed
////////////////////

module rv_ex_tb
  import rv_ex_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          CLK_PERIOD = 40;
  localparam int          DRIVE_DLY  = 2;
  localparam int          FIELDS     = 7;
  localparam int          MAX_CASES  = 64;
  localparam logic [31:0] LFSR_SEED  = 32'hdb0b_78cc;
  localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
  localparam logic [31:0] END_MARK   = 32'hffff_ffff;

  logic            clk;
  logic            rstn;
  logic            ex_stall;
  id_pkt_t         id;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  ex_res_t         res;

  logic [31:0]     case_mem [0:MAX_CASES*FIELDS-1];
  int              n_cases = 0;
  logic [31:0]     lfsr;
  ex_res_t         last_res;

  rv_ex_top u_rv_ex_top (
    .clk      (clk),
    .rstn     (rstn),
    .ex_stall (ex_stall),
    .id       (id),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val),
    .res      (res)
  );

  // 40 ns clock
  always begin
    clk = 1'b0;
    #(CLK_PERIOD/2);
    clk = 1'b1;
    #(CLK_PERIOD/2);
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on first failure");
  endtask

  // Galois LFSR, right shifting
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // One LFSR step per bit taken, LSB first out
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  function automatic ex_res_t expected_res(input int idx);
    ex_res_t e;
    e.bubble = case_mem[idx*FIELDS+5][0];
    e.r      = case_mem[idx*FIELDS+6];
    return e;
  endfunction

  task automatic check_res(input ex_res_t got, input ex_res_t exp, input int idx);
    if (got !== exp) begin
      abort_run($sformatf("ERROR %0t: case %0d res bubble=%0b r=%08h, expected bubble=%0b r=%08h",
                          $time, idx, got.bubble, got.r, exp.bubble, exp.r));
    end
  endtask

  task automatic check_bubble_hold(input ex_res_t got, input ex_res_t held, input int idx);
    if (got !== held) begin
      abort_run($sformatf("ERROR %0t: stall before case %0d, res bubble=%0b r=%08h, held %0b %08h",
                          $time, idx, got.bubble, got.r, held.bubble, held.r));
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic drive_case(input int idx);
    id.pc     = case_mem[idx*FIELDS+0];
    id.instr  = case_mem[idx*FIELDS+1];
    rs1_val   = case_mem[idx*FIELDS+2];
    rs2_val   = case_mem[idx*FIELDS+3];
    id.bubble = case_mem[idx*FIELDS+4][0];
  endtask

  // Garbage packet, only seen while stalled
  task automatic scramble_inputs();
    logic [31:0] v;
    take_bits(32, v);
    id.pc = v;
    take_bits(32, v);
    id.instr = v;
    take_bits(32, v);
    rs1_val = v;
    take_bits(32, v);
    rs2_val = v;
    take_bits(1, v);
    id.bubble = v[0];
  endtask

  task automatic load_cases();
    bit found;
    found = 1'b0;
    $readmemh("bench/ex_cases.txt", case_mem);
    for (int i = 0; i < MAX_CASES && !found; i++) begin
      if (case_mem[i*FIELDS+4] === END_MARK) begin
        found   = 1'b1;
        n_cases = i;
      end
    end
  endtask

  task automatic reset_dut();
    ex_res_t rst_res;
    rst_res = '{bubble: 1'b1, r: '0};
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    rstn = 1'b1;
    check_res(res, rst_res, -1);
    last_res = rst_res;
  endtask

  task automatic run_cases();
    logic [31:0] b;
    for (int i = 0; i < n_cases; i++) begin
      take_bits(1, b);
      if (b[0]) begin
        // Stalled cycle shows either junk or the next case early
        take_bits(1, b);
        if (b[0]) begin
          drive_case(i);
        end else begin
          scramble_inputs();
        end
        ex_stall = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        check_bubble_hold(res, last_res, i);
      end
      drive_case(i);
      ex_stall = 1'b0;
      @(posedge clk);
      #DRIVE_DLY;
      check_res(res, expected_res(i), i);
      last_res = expected_res(i);
    end
  endtask

  initial begin : main
    rstn      = 1'b0;
    ex_stall  = 1'b0;
    id        = '0;
    id.bubble = 1'b1;
    rs1_val   = '0;
    rs2_val   = '0;
    lfsr      = LFSR_SEED;
    load_cases();
    if (n_cases == 0) begin
      abort_run("Case file bench/ex_cases.txt is missing, empty or has no end marker");
    end else begin
      reset_dut();
      run_cases();
      $display("TEST PASS");
      $finish;
    end
  end

  // At most two cycles per case plus reset
  initial begin : watchdog
    wait (n_cases > 0);
    #((n_cases * 2 + 10) * CLK_PERIOD);
    abort_run("Timeout: the test did not finish in the expected number of cycles");
  end

endmodule

// ==== bench/rv_ex_assertions.sv ====
////////////////////
// Protocol checks on the ALU, bound into every rv_alu
////////////////////

module rv_ex_assertions
  import rv_ex_pkg::*;
(
  input logic            clk,
  input logic            rstn,
  input logic            ex_stall,
  input logic [XLEN-1:0] csr_rval,
  input ex_res_t         res,
  input csr_wr_t         csr_wr
);

  timeunit 1ns;
  timeprecision 100ps;

  // Reset leaves a bubble
  a_reset_bubble: assert property (@(posedge clk) $rose(rstn) |-> res.bubble)
    else $error("res.bubble low in the first cycle after reset");

  // Stall freezes the result register
  a_stall_hold: assert property (@(posedge clk) disable iff (!rstn) ex_stall |=> $stable(res))
    else $error("res changed across a stalled cycle");

  // A CSR commit retires a live result carrying the value before the write
  a_csr_we: assert property (@(posedge clk) disable iff (!rstn)
                             csr_wr.we |=> (!res.bubble && (res.r == $past(csr_rval))))
    else $error("CSR write enable without a matching unstalled, non-bubble result");

endmodule

bind rv_alu rv_ex_assertions u_assertions (
  .clk      (clk),
  .rstn     (rstn),
  .ex_stall (ex_stall),
  .csr_rval (csr_rval),
  .res      (res),
  .csr_wr   (csr_wr)
);

// ==== hw/rv_ex_top.sv ====
////////////////////
// Execute stage, one cycle from id to res
// ex_stall freezes result and CSR writes together
////////////////////

module rv_ex_top
  import rv_ex_pkg::*;
(
  input  logic            clk,
  input  logic            rstn,
  input  logic            ex_stall,
  input  id_pkt_t         id,
  input  logic [XLEN-1:0] rs1_val,
  input  logic [XLEN-1:0] rs2_val,
  output ex_res_t         res
);

  // Stage internal nets
  ops_t            ops;
  csr_wr_t         csr_wr;
  logic [XLEN-1:0] csr_rval;

  // Operands, combinational
  rv_operand_sel u_operand_sel (
    .id      (id),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .ops     (ops)
  );

  // Result register and CSR request
  rv_alu u_alu (
    .clk      (clk),
    .rstn     (rstn),
    .ex_stall (ex_stall),
    .id       (id),
    .ops      (ops),
    .csr_rval (csr_rval),
    .res      (res),
    .csr_wr   (csr_wr)
  );

  // CSR state
  rv_csr_file u_csr_file (
    .clk      (clk),
    .rstn     (rstn),
    .id       (id),
    .csr_wr   (csr_wr),
    .csr_rval (csr_rval)
  );

endmodule

// ==== hw/rv_csr_file.sv ====
////////////////////
// Minimal machine-mode CSR file, four registers
// Read is combinational off the instruction in ID, write is clocked
// Stall is handled by the writer, we is trusted as is
////////////////////

module rv_csr_file
  import rv_ex_pkg::*;
(
  input  logic            clk,
  input  logic            rstn,
  input  id_pkt_t         id,
  input  csr_wr_t         csr_wr,
  output logic [XLEN-1:0] csr_rval
);

  logic [11:0]     rd_addr;
  logic [XLEN-1:0] mscratch;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;

  ////////////////////
  // Read port
  ////////////////////

  // CSR address field of the current instruction
  assign rd_addr = id.instr[31:20];

  always_comb begin
    case (rd_addr)
      CSR_MSCRATCH: csr_rval = mscratch;
      CSR_MTVEC:    csr_rval = mtvec;
      CSR_MEPC:     csr_rval = mepc;
      CSR_MCAUSE:   csr_rval = mcause;
      // Unimplemented reads as zero
      default:      csr_rval = '0;
    endcase
  end

  ////////////////////
  // Write port
  ////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mscratch <= '0;
      mtvec    <= '0;
      mepc     <= '0;
      mcause   <= '0;
    end else if (csr_wr.we) begin
      case (csr_wr.addr)
        CSR_MSCRATCH: mscratch <= csr_wr.wval;
        // Base is word aligned, mode bits tied off
        CSR_MTVEC:    mtvec    <= {csr_wr.wval[XLEN-1:2], 2'b00};
        CSR_MEPC:     mepc     <= csr_wr.wval;
        CSR_MCAUSE:   mcause   <= csr_wr.wval;
        // Write to anything else is dropped
        default: begin
          mscratch <= mscratch;
        end
      endcase
    end
  end

endmodule

// ==== hw/rv_alu.sv ====
////////////////////
// Registered RV32I ALU with CSR read-modify-write generation
// Illegal encodings leave a bubble with result 0
// csr_wr is combinational and only valid for an unstalled, non-bubble CSR op
////////////////////

module rv_alu
  import rv_ex_pkg::*;
(
  input  logic            clk,
  input  logic            rstn,
  input  logic            ex_stall,
  input  id_pkt_t         id,
  input  ops_t            ops,
  input  logic [XLEN-1:0] csr_rval,
  output ex_res_t         res,
  output csr_wr_t         csr_wr
);

  opc_e             opc;
  alu_f3_e          f3;
  csr_op_e          csr_op;
  logic [6:0]       f7;
  logic [SBITS-1:0] shamt;
  logic             alt;
  logic [XLEN-1:0]  alu_nxt;
  logic             legal;
  logic             is_csr;
  logic             csr_upd;

  ////////////////////
  // Decode
  ////////////////////

  assign opc    = opc_e'(id.instr[6:2]);
  assign f3     = alu_f3_e'(id.instr[14:12]);
  assign csr_op = csr_op_e'(id.instr[14:12]);
  assign f7     = id.instr[31:25];
  assign shamt  = ops.opb[SBITS-1:0];

  // SUB/SRA select, in OP_IMM only shifts carry func7
  assign alt = id.instr[30] && ((opc == OPC_OP) || (f3 == F3_SR));

  ////////////////////
  // Next result
  ////////////////////

  always_comb begin
    alu_nxt = '0;
    legal   = 1'b0;
    is_csr  = 1'b0;
    case (opc)
      // LUI has zero in opa, so one adder serves both
      OPC_LUI, OPC_AUIPC: begin
        alu_nxt = ops.opa + ops.opb;
        legal   = 1'b1;
      end
      // Link address
      OPC_JAL: begin
        alu_nxt = id.pc + XLEN'(4);
        legal   = 1'b1;
      end
      OPC_JALR: begin
        alu_nxt = id.pc + XLEN'(4);
        legal   = (f3 == F3_ADD);
      end
      OPC_OP, OPC_OP_IMM: begin
        case (f3)
          F3_ADD:  alu_nxt = alt ? ops.opa - ops.opb : ops.opa + ops.opb;
          F3_SLL:  alu_nxt = ops.opa << shamt;
          F3_SLT:  alu_nxt = {{(XLEN-1){1'b0}}, $signed(ops.opa) < $signed(ops.opb)};
          F3_SLTU: alu_nxt = {{(XLEN-1){1'b0}}, ops.opa < ops.opb};
          F3_XOR:  alu_nxt = ops.opa ^ ops.opb;
          F3_SR: begin
            // Kept apart so the signed shift is not mixed with unsigned
            if (alt) begin
              alu_nxt = $signed(ops.opa) >>> shamt;
            end else begin
              alu_nxt = ops.opa >> shamt;
            end
          end
          F3_OR:   alu_nxt = ops.opa | ops.opb;
          F3_AND:  alu_nxt = ops.opa & ops.opb;
          default: alu_nxt = '0;
        endcase
        // func7 checks
        if (opc == OPC_OP) begin
          legal = (f7 == F7_BASE) || ((f7 == F7_ALT) && ((f3 == F3_ADD) || (f3 == F3_SR)));
        end else if (f3 == F3_SLL) begin
          legal = (f7 == F7_BASE);
        end else if (f3 == F3_SR) begin
          legal = (f7 == F7_BASE) || (f7 == F7_ALT);
        end else begin
          legal = 1'b1;
        end
      end
      // Old CSR value goes to rd
      OPC_SYSTEM: begin
        alu_nxt = csr_rval;
        legal   = csr_op inside {CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI};
        is_csr  = legal;
      end
      default: begin
        alu_nxt = '0;
      end
    endcase
    // Compressed encodings are illegal here
    if (id.instr[1:0] != 2'b11) begin
      legal  = 1'b0;
      is_csr = 1'b0;
    end
  end

  ////////////////////
  // Result register
  ////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      res.bubble <= 1'b1;
      res.r      <= '0;
    end else if (!ex_stall) begin
      res.bubble <= id.bubble | ~legal;
      res.r      <= (id.bubble || !legal) ? '0 : alu_nxt;
    end
  end

  ////////////////////
  // CSR write request
  ////////////////////

  always_comb begin
    csr_wr.addr = id.instr[31:20];
    csr_wr.wval = '0;
    csr_upd     = 1'b0;
    case (csr_op)
      // Write forms always update
      CSR_RW: begin
        csr_wr.wval = ops.opa;
        csr_upd     = 1'b1;
      end
      CSR_RWI: begin
        csr_wr.wval = ops.opb;
        csr_upd     = 1'b1;
      end
      // Set and clear only with a nonzero mask
      CSR_RS: begin
        csr_wr.wval = csr_rval | ops.opa;
        csr_upd     = |ops.opa;
      end
      CSR_RSI: begin
        csr_wr.wval = csr_rval | ops.opb;
        csr_upd     = |ops.opb;
      end
      CSR_RC: begin
        csr_wr.wval = csr_rval & ~ops.opa;
        csr_upd     = |ops.opa;
      end
      CSR_RCI: begin
        csr_wr.wval = csr_rval & ~ops.opb;
        csr_upd     = |ops.opb;
      end
      default: begin
        csr_upd = 1'b0;
      end
    endcase
    // Commit together with the result register
    csr_wr.we = is_csr & csr_upd & ~id.bubble & ~ex_stall;
  end

endmodule

// ==== hw/rv_operand_sel.sv ====
////////////////////
// Combinational operand selection in front of the ALU
// Unknown opcodes and JAL get zero operands
////////////////////

module rv_operand_sel
  import rv_ex_pkg::*;
(
  input  id_pkt_t         id,
  input  logic [XLEN-1:0] rs1_val,
  input  logic [XLEN-1:0] rs2_val,
  output ops_t            ops
);

  opc_e            opc;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] zimm;

  ////////////////////
  // Field extraction
  ////////////////////

  assign opc = opc_e'(id.instr[6:2]);

  // I-type, sign extended from bit 31
  assign imm_i = {{(XLEN-12){id.instr[31]}}, id.instr[31:20]};

  // U-type, low 12 bits zero
  assign imm_u = {id.instr[31:12], 12'h000};

  // CSR immediate sits in the rs1 field
  assign zimm = {{(XLEN-5){1'b0}}, id.instr[19:15]};

  ////////////////////
  // Operand mux
  ////////////////////

  always_comb begin
    ops = '0;
    case (opc)
      // opa stays zero, ALU adds it anyway
      OPC_LUI: begin
        ops.opb = imm_u;
      end
      OPC_AUIPC: begin
        ops.opa = id.pc;
        ops.opb = imm_u;
      end
      // JALR target calc is not done here, only the operands
      OPC_JALR, OPC_OP_IMM: begin
        ops.opa = rs1_val;
        ops.opb = imm_i;
      end
      OPC_OP: begin
        ops.opa = rs1_val;
        ops.opb = rs2_val;
      end
      // Register forms use opa, immediate forms use opb
      OPC_SYSTEM: begin
        ops.opa = rs1_val;
        ops.opb = zimm;
      end
      default: begin
        ops = '0;
      end
    endcase
  end

endmodule

// ==== hw/rv_ex_pkg.sv ====
////////////////////
// Shared types and constants of the RV32I execute stage
// XLEN is fixed at 32, RV64 W-forms and RVC are not supported
////////////////////

package rv_ex_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Data and instruction word
  localparam int XLEN  = 32;
  localparam int ILEN  = 32;
  // Shift amount bits
  localparam int SBITS = $clog2(XLEN);

  // func7 patterns for OP and the immediate shifts
  localparam logic [6:0] F7_BASE = 7'b000_0000;
  localparam logic [6:0] F7_ALT  = 7'b010_0000;

  ////////////////////
  // Encodings
  ////////////////////

  // Major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    OPC_LUI    = 5'b01101,
    OPC_AUIPC  = 5'b00101,
    OPC_JAL    = 5'b11011,
    OPC_JALR   = 5'b11001,
    OPC_OP_IMM = 5'b00100,
    OPC_OP     = 5'b01100,
    OPC_SYSTEM = 5'b11100
  } opc_e;

  // func3 of OP and OP_IMM
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } alu_f3_e;

  // func3 of SYSTEM, 000 and 100 are not CSR accesses
  typedef enum logic [2:0] {
    CSR_RW  = 3'b001,
    CSR_RS  = 3'b010,
    CSR_RC  = 3'b011,
    CSR_RWI = 3'b101,
    CSR_RSI = 3'b110,
    CSR_RCI = 3'b111
  } csr_op_e;

  // Implemented machine-mode CSRs
  localparam logic [11:0] CSR_MTVEC    = 12'h305;
  localparam logic [11:0] CSR_MSCRATCH = 12'h340;
  localparam logic [11:0] CSR_MEPC     = 12'h341;
  localparam logic [11:0] CSR_MCAUSE   = 12'h342;

  ////////////////////
  // Bundles
  ////////////////////

  // Decoded instruction from ID
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [ILEN-1:0] instr;
    logic            bubble;
  } id_pkt_t;

  // ALU operands
  typedef struct packed {
    logic [XLEN-1:0] opa;
    logic [XLEN-1:0] opb;
  } ops_t;

  // CSR write request
  typedef struct packed {
    logic [11:0]     addr;
    logic [XLEN-1:0] wval;
    logic            we;
  } csr_wr_t;

  // Stage result toward write-back
  typedef struct packed {
    logic            bubble;
    logic [XLEN-1:0] r;
  } ex_res_t;

endpackage
